//--- source/mm_defines.svh
`ifndef MM_DEFINES_SVH
`define MM_DEFINES_SVH

// matrix geometry
`define MM_DIM        4
`define MM_WORD_W     32

// AXI4-Lite control port
`define MM_ADDR_W     12
`define MM_CTRL_ADDR  12'h000

// control register bit positions
`define MM_BIT_START  0
`define MM_BIT_DONE   1
`define MM_BIT_IDLE   2

// words per job, A then B in, C out
`define MM_IN_WORDS   32
`define MM_OUT_WORDS  16

`endif

//--- source/mm_pkg.sv
`include "mm_defines.svh"

package mm_pkg;

    // one matrix element, also the bus data word
    typedef logic [`MM_WORD_W-1:0] mm_word_t;

    // row or column index into a 4x4 matrix
    typedef logic [1:0] mm_idx_t;

    // ------------------------------
    // job phases
    // ------------------------------
    // drain is a spare encoding, the FSM never enters it
    typedef enum logic [1:0] {
        phase_idle    = 2'd0,
        phase_load    = 2'd1,
        phase_compute = 2'd2,
        phase_drain   = 2'd3
    } mm_phase_t;

endpackage

//--- source/mm_job_if.sv
`timescale 1ns/100ps

interface mm_job_if;

    // from the sequencer
    logic load_en;
    logic run;
    logic job_end;

    // single-cycle pulses back to the sequencer
    logic load_full;
    logic run_done;

    modport sequencer (output load_en, output run, output job_end,
                       input load_full, input run_done);

    modport loader (input load_en, output load_full);

    modport engine (input run, output run_done);

endinterface

//--- source/mm_operand_if.sv
`timescale 1ns/100ps
`include "mm_defines.svh"

interface mm_operand_if;

    // element position chosen by the engine
    mm_pkg::mm_idx_t  row_sel;
    mm_pkg::mm_idx_t  col_sel;

    // operands served combinationally by the loader
    mm_pkg::mm_word_t a_row [`MM_DIM];
    mm_pkg::mm_word_t b_col [`MM_DIM];

    modport engine (output row_sel, output col_sel,
                    input a_row, input b_col);

    modport loader (input row_sel, input col_sel,
                    output a_row, output b_col);

endinterface

//--- source/mm_axil_regs.sv
`timescale 1ns/100ps
`include "mm_defines.svh"

module mm_axil_regs (
    input  logic                    axis_clk,
    input  logic                    axis_rst_n,
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [`MM_ADDR_W-1:0]   awaddr,
    input  logic                    wvalid,
    output logic                    wready,
    input  mm_pkg::mm_word_t        wdata,
    input  logic [`MM_WORD_W/8-1:0] wstrb,
    output logic                    bvalid,
    input  logic                    bready,
    output logic [1:0]              bresp,
    input  logic                    arvalid,
    output logic                    arready,
    input  logic [`MM_ADDR_W-1:0]   araddr,
    output logic                    rvalid,
    input  logic                    rready,
    output mm_pkg::mm_word_t        rdata,
    output logic [1:0]              rresp,
    input  logic                    idle,
    input  logic                    job_end,
    output logic                    start_req
);
    import mm_pkg::*;

    logic     wr_rdy_q;
    logic     bvalid_q;
    logic     arready_q;
    logic     rvalid_q;
    logic     done_q;
    mm_word_t rdata_q;

    // ------------------------------
    // write channel
    // ------------------------------
    // address and data accepted together, one write outstanding at a time
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            wr_rdy_q <= 1'b0;
            bvalid_q <= 1'b0;
        end else begin
            wr_rdy_q <= awvalid && wvalid && !wr_rdy_q && !bvalid_q;
            if (wr_rdy_q) begin
                bvalid_q <= 1'b1;
            end else if (bready) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    assign awready = wr_rdy_q;
    assign wready  = wr_rdy_q;
    assign bvalid  = bvalid_q;
    assign bresp   = 2'b00;

    // start only honoured when no job is running
    assign start_req = wr_rdy_q && (awaddr == `MM_CTRL_ADDR) && wstrb[0]
                       && wdata[`MM_BIT_START] && idle;

    // ------------------------------
    // read channel
    // ------------------------------
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            arready_q <= 1'b0;
            rvalid_q  <= 1'b0;
        end else begin
            arready_q <= arvalid && !arready_q && !rvalid_q;
            if (arready_q) begin
                rvalid_q <= 1'b1;
            end else if (rready) begin
                rvalid_q <= 1'b0;
            end
        end
    end

    // status snapshot taken on the address handshake
    always_ff @(posedge axis_clk) begin
        if (arready_q) begin
            rdata_q <= '0;
            if (araddr == `MM_CTRL_ADDR) begin
                rdata_q[`MM_BIT_DONE] <= done_q;
                rdata_q[`MM_BIT_IDLE] <= idle;
            end
        end
    end

    // sticky done, cleared once a read has carried it out
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            done_q <= 1'b0;
        end else if (job_end) begin
            done_q <= 1'b1;
        end else if (rvalid_q && rready && rdata_q[`MM_BIT_DONE]) begin
            done_q <= 1'b0;
        end
    end

    assign arready = arready_q;
    assign rvalid  = rvalid_q;
    assign rdata   = rdata_q;
    assign rresp   = 2'b00;

    // write response must stay up until the master takes it
    assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        bvalid && !bready |=> bvalid);

endmodule

//--- source/mm_sequencer.sv
`timescale 1ns/100ps

module mm_sequencer (
    input  logic          axis_clk,
    input  logic          axis_rst_n,
    input  logic          start_req,
    output logic          idle,
    mm_job_if.sequencer   job
);
    import mm_pkg::*;

    mm_phase_t phase_q;

    // ------------------------------
    // phase FSM
    // ------------------------------
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            phase_q <= phase_idle;
        end else begin
            case (phase_q)
                phase_idle: begin
                    if (start_req) begin
                        phase_q <= phase_load;
                    end
                end
                phase_load: begin
                    if (job.load_full) begin
                        phase_q <= phase_compute;
                    end
                end
                phase_compute: begin
                    // last output accepted downstream
                    if (job.run_done) begin
                        phase_q <= phase_idle;
                    end
                end
                default:     phase_q <= phase_idle;
            endcase
        end
    end

    assign idle        = (phase_q == phase_idle);
    assign job.load_en = (phase_q == phase_load);
    assign job.run     = (phase_q == phase_compute);
    assign job.job_end = job.run_done && (phase_q == phase_compute);

    // register block must gate start with idle
    assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        start_req |-> phase_q == phase_idle);

endmodule

//--- source/mm_operand_loader.sv
`timescale 1ns/100ps
`include "mm_defines.svh"

module mm_operand_loader (
    input  logic             axis_clk,
    input  logic             axis_rst_n,
    input  logic             ss_tvalid,
    output logic             ss_tready,
    input  mm_pkg::mm_word_t ss_tdata,
    input  logic             ss_tlast,
    mm_job_if.loader         job,
    mm_operand_if.loader     ops
);
    import mm_pkg::*;

    localparam int ELEMS = `MM_DIM * `MM_DIM;
    localparam int IDX_W = $clog2(ELEMS);

    logic [$clog2(`MM_IN_WORDS)-1:0] cnt_q;
    logic                            hs;
    mm_word_t                        a_mem [ELEMS];
    mm_word_t                        b_mem [ELEMS];

    // accept input only during the load phase
    assign ss_tready     = job.load_en;
    assign hs            = ss_tvalid && ss_tready;
    assign job.load_full = hs && (cnt_q == `MM_IN_WORDS - 1);

    // ------------------------------
    // word counter
    // ------------------------------
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            cnt_q <= '0;
        end else if (!job.load_en) begin
            cnt_q <= '0;
        end else if (hs) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // first 16 words fill A, the rest fill B, both row-major
    always_ff @(posedge axis_clk) begin
        if (hs) begin
            if (cnt_q < ELEMS) begin
                a_mem[cnt_q[IDX_W-1:0]] <= ss_tdata;
            end else begin
                b_mem[cnt_q[IDX_W-1:0]] <= ss_tdata;
            end
        end
    end

    // row of A and column of B for the engine
    always_comb begin
        for (int k = 0; k < `MM_DIM; k++) begin
            ops.a_row[k] = a_mem[ops.row_sel * `MM_DIM + k];
            ops.b_col[k] = b_mem[k * `MM_DIM + ops.col_sel];
        end
    end

    assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        hs && ss_tlast |-> cnt_q == `MM_IN_WORDS - 1);

endmodule

//--- source/mm_multiply_engine.sv
`timescale 1ns/100ps
`include "mm_defines.svh"

module mm_multiply_engine (
    input  logic             axis_clk,
    input  logic             axis_rst_n,
    output logic             sm_tvalid,
    input  logic             sm_tready,
    output mm_pkg::mm_word_t sm_tdata,
    output logic             sm_tlast,
    mm_job_if.engine         job,
    mm_operand_if.engine     ops
);
    import mm_pkg::*;

    localparam int POS_W = $clog2(`MM_OUT_WORDS);
    localparam logic [POS_W-1:0] POS_LAST = POS_W'(`MM_OUT_WORDS - 1);

    logic [POS_W-1:0] pos_q;
    logic             issue_done_q;
    logic             issue;
    logic             advance;
    mm_idx_t          row_q;
    mm_idx_t          col_q;
    logic             sel_valid_q;
    logic             sel_last_q;
    mm_word_t         prod_q [`MM_DIM];
    logic             prod_valid_q;
    logic             prod_last_q;
    mm_word_t         sum;
    mm_word_t         out_q;
    logic             out_valid_q;
    logic             out_last_q;

    // whole pipe holds while the output is blocked
    assign advance = !(out_valid_q && !sm_tready);
    assign issue   = job.run && !issue_done_q;

    // ------------------------------
    // control and valid flags
    // ------------------------------
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            pos_q        <= '0;
            issue_done_q <= 1'b0;
            sel_valid_q  <= 1'b0;
            sel_last_q   <= 1'b0;
            prod_valid_q <= 1'b0;
            prod_last_q  <= 1'b0;
            out_valid_q  <= 1'b0;
            out_last_q   <= 1'b0;
        end else if (advance) begin
            sel_valid_q  <= issue;
            sel_last_q   <= issue && (pos_q == POS_LAST);
            prod_valid_q <= sel_valid_q;
            prod_last_q  <= sel_last_q;
            out_valid_q  <= prod_valid_q;
            out_last_q   <= prod_last_q;
            if (!job.run) begin
                pos_q        <= '0;
                issue_done_q <= 1'b0;
            end else if (!issue_done_q) begin
                pos_q <= pos_q + 1'b1;
                if (pos_q == POS_LAST) begin
                    issue_done_q <= 1'b1;
                end
            end
        end
    end

    // ------------------------------
    // datapath
    // ------------------------------
    // select, products, then the sum, all truncated to 32 bits
    always_ff @(posedge axis_clk) begin
        if (advance) begin
            row_q <= mm_idx_t'(pos_q / `MM_DIM);
            col_q <= mm_idx_t'(pos_q % `MM_DIM);
            for (int k = 0; k < `MM_DIM; k++) begin
                prod_q[k] <= ops.a_row[k] * ops.b_col[k];
            end
            out_q <= sum;
        end
    end

    always_comb begin
        sum = '0;
        for (int k = 0; k < `MM_DIM; k++) begin
            sum = sum + prod_q[k];
        end
    end

    assign ops.row_sel  = row_q;
    assign ops.col_sel  = col_q;
    assign sm_tvalid    = out_valid_q;
    assign sm_tdata     = out_q;
    assign sm_tlast     = out_last_q;
    assign job.run_done = out_valid_q && sm_tready && out_last_q;

    // output word must not move under back-pressure
    assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_tdata));

endmodule

//--- source/mm_accel.sv
`timescale 1ns/100ps
`include "mm_defines.svh"

module mm_accel (
    input  logic                    axis_clk,
    input  logic                    axis_rst_n,
    // AXI4-Lite control
    input  logic                    awvalid,
    output logic                    awready,
    input  logic [`MM_ADDR_W-1:0]   awaddr,
    input  logic                    wvalid,
    output logic                    wready,
    input  mm_pkg::mm_word_t        wdata,
    input  logic [`MM_WORD_W/8-1:0] wstrb,
    output logic                    bvalid,
    input  logic                    bready,
    output logic [1:0]              bresp,
    input  logic                    arvalid,
    output logic                    arready,
    input  logic [`MM_ADDR_W-1:0]   araddr,
    output logic                    rvalid,
    input  logic                    rready,
    output mm_pkg::mm_word_t        rdata,
    output logic [1:0]              rresp,
    // operand stream in
    input  logic                    ss_tvalid,
    output logic                    ss_tready,
    input  mm_pkg::mm_word_t        ss_tdata,
    input  logic                    ss_tlast,
    // result stream out
    output logic                    sm_tvalid,
    input  logic                    sm_tready,
    output mm_pkg::mm_word_t        sm_tdata,
    output logic                    sm_tlast
);

    logic start_req;
    logic idle;

    mm_job_if     job_if ();
    mm_operand_if operand_if ();

    mm_axil_regs u_regs (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .bvalid     (bvalid),
        .bready     (bready),
        .bresp      (bresp),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .rresp      (rresp),
        .idle       (idle),
        .job_end    (job_if.job_end),
        .start_req  (start_req)
    );

    mm_sequencer u_seq (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .start_req  (start_req),
        .idle       (idle),
        .job        (job_if.sequencer)
    );

    mm_operand_loader u_loader (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .ss_tvalid  (ss_tvalid),
        .ss_tready  (ss_tready),
        .ss_tdata   (ss_tdata),
        .ss_tlast   (ss_tlast),
        .job        (job_if.loader),
        .ops        (operand_if.loader)
    );

    mm_multiply_engine u_engine (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .sm_tvalid  (sm_tvalid),
        .sm_tready  (sm_tready),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast),
        .job        (job_if.engine),
        .ops        (operand_if.engine)
    );

endmodule

//--- verif/tb_mm_accel.sv
`timescale 1ns/100ps
`include "mm_defines.svh"

module tb_mm_accel;
    import mm_pkg::*;

    localparam time HALF_PERIOD = 50;
    localparam time DRV_DLY     = 10;
    localparam int  LIMIT       = 2000;
    localparam int  ELEMS       = `MM_DIM * `MM_DIM;

    logic                    axis_clk;
    logic                    axis_rst_n;
    logic                    awvalid;
    logic                    awready;
    logic [`MM_ADDR_W-1:0]   awaddr;
    logic                    wvalid;
    logic                    wready;
    mm_word_t                wdata;
    logic [`MM_WORD_W/8-1:0] wstrb;
    logic                    bvalid;
    logic                    bready;
    logic [1:0]              bresp;
    logic                    arvalid;
    logic                    arready;
    logic [`MM_ADDR_W-1:0]   araddr;
    logic                    rvalid;
    logic                    rready;
    mm_word_t                rdata;
    logic [1:0]              rresp;
    logic                    ss_tvalid;
    logic                    ss_tready;
    mm_word_t                ss_tdata;
    logic                    ss_tlast;
    logic                    sm_tvalid;
    logic                    sm_tready;
    mm_word_t                sm_tdata;
    logic                    sm_tlast;

    integer   seed;
    logic     bp_en;
    logic     bp_now;
    int       out_cnt;
    mm_word_t rd_val;
    mm_word_t a_mat [ELEMS];
    mm_word_t b_mat [ELEMS];
    mm_word_t exp_c [ELEMS];

    mm_accel DUT (.*);

    initial axis_clk = 1'b0;
    always #HALF_PERIOD axis_clk = ~axis_clk;

    // ------------------------------
    // helpers
    // ------------------------------
    task automatic stop_run(input string line);
        $display("%s", line);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    // C = A*B, every sum truncated to the word width
    function automatic void mm_ref();
        mm_word_t acc;
        for (int r = 0; r < `MM_DIM; r++) begin
            for (int c = 0; c < `MM_DIM; c++) begin
                acc = '0;
                for (int k = 0; k < `MM_DIM; k++) begin
                    acc = acc + a_mat[r * `MM_DIM + k] * b_mat[k * `MM_DIM + c];
                end
                exp_c[r * `MM_DIM + c] = acc;
            end
        end
    endfunction

    task automatic axil_write(input logic [`MM_ADDR_W-1:0] addr, input mm_word_t data);
        int   cycles;
        logic got;
        awaddr  = addr;
        wdata   = data;
        wstrb   = '1;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        got     = 1'b0;
        for (cycles = 0; cycles < LIMIT && !got; cycles++) begin
            @(posedge axis_clk);
            got = awready && wready;
        end
        if (!got) stop_run("timeout: write address and data never accepted");
        #DRV_DLY;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        got     = 1'b0;
        for (cycles = 0; cycles < LIMIT && !got; cycles++) begin
            @(posedge axis_clk);
            got = bvalid;
        end
        if (!got) stop_run("timeout: no write response from the DUT");
        assert (bresp == 2'b00) else
            stop_run($sformatf("CHECK FAILED at %0t: bresp is %0d", $time, bresp));
        #DRV_DLY;
        bready = 1'b0;
    endtask

    task automatic axil_read(input logic [`MM_ADDR_W-1:0] addr, output mm_word_t data);
        int   cycles;
        logic got;
        araddr  = addr;
        arvalid = 1'b1;
        got     = 1'b0;
        for (cycles = 0; cycles < LIMIT && !got; cycles++) begin
            @(posedge axis_clk);
            got = arready;
        end
        if (!got) stop_run("timeout: read address never accepted");
        #DRV_DLY;
        arvalid = 1'b0;
        rready  = 1'b1;
        got     = 1'b0;
        for (cycles = 0; cycles < LIMIT && !got; cycles++) begin
            @(posedge axis_clk);
            got  = rvalid;
            data = rdata;
        end
        if (!got) stop_run("timeout: no read data from the DUT");
        assert (rresp == 2'b00) else
            stop_run($sformatf("CHECK FAILED at %0t: rresp is %0d", $time, rresp));
        #DRV_DLY;
        rready = 1'b0;
    endtask

    task automatic check_status(input mm_word_t got, input logic done, input logic idle,
                                input string what);
        mm_word_t want;
        want = '0;
        want[`MM_BIT_DONE] = done;
        want[`MM_BIT_IDLE] = idle;
        assert (got == want) else
            stop_run($sformatf("CHECK FAILED at %0t: %s read 0x%08h, expected 0x%08h",
                               $time, what, got, want));
    endtask

    task automatic gen_matrices();
        for (int n = 0; n < ELEMS; n++) begin
            a_mat[n] = $random(seed);
            b_mat[n] = $random(seed);
        end
        mm_ref();
    endtask

    // A then B, with random idle cycles on tvalid
    task automatic send_matrices();
        int sent;
        int cycles;
        sent = 0;
        for (cycles = 0; cycles < LIMIT && sent < `MM_IN_WORDS; cycles++) begin
            ss_tvalid = ($random(seed) & 3) != 0;
            ss_tdata  = (sent < ELEMS) ? a_mat[sent] : b_mat[sent - ELEMS];
            ss_tlast  = (sent == `MM_IN_WORDS - 1);
            @(posedge axis_clk);
            if (ss_tvalid && ss_tready) begin
                sent++;
            end
            #DRV_DLY;
        end
        ss_tvalid = 1'b0;
        ss_tlast  = 1'b0;
        if (sent < `MM_IN_WORDS) stop_run("timeout: operand stream was not accepted");
    endtask

    task automatic wait_outputs();
        int   cycles;
        logic got;
        got = 1'b0;
        for (cycles = 0; cycles < LIMIT && !got; cycles++) begin
            @(posedge axis_clk);
            got = (out_cnt == `MM_OUT_WORDS);
        end
        if (!got) stop_run("timeout: result stream did not deliver 16 elements");
        #DRV_DLY;
    endtask

    task automatic run_job(input logic busy_start);
        gen_matrices();
        out_cnt = 0;
        axil_write(`MM_CTRL_ADDR, 32'h1);
        send_matrices();
        bp_en = 1'b1;
        // a start while computing must be dropped
        if (busy_start) begin
            axil_write(`MM_CTRL_ADDR, 32'h1);
        end
        wait_outputs();
        bp_en = 1'b0;
    endtask

    // ------------------------------
    // back-pressure and checker
    // ------------------------------
    // bp_en sampled at the edge so only one process draws from seed per step
    always begin
        @(posedge axis_clk);
        bp_now = bp_en;
        #DRV_DLY;
        sm_tready = bp_now ? (($random(seed) & 3) != 0) : 1'b1;
    end

    always @(posedge axis_clk) begin
        if (axis_rst_n && sm_tvalid && sm_tready) begin
            assert (out_cnt < `MM_OUT_WORDS) else
                stop_run($sformatf("CHECK FAILED at %0t: extra output beyond 16", $time));
            assert (sm_tdata == exp_c[out_cnt]) else
                stop_run($sformatf("CHECK FAILED at %0t: element %0d is 0x%08h, expected 0x%08h",
                                   $time, out_cnt, sm_tdata, exp_c[out_cnt]));
            assert (sm_tlast == (out_cnt == `MM_OUT_WORDS - 1)) else
                stop_run($sformatf("CHECK FAILED at %0t: tlast %0b on element %0d",
                                   $time, sm_tlast, out_cnt));
            out_cnt <= out_cnt + 1;
        end
    end

    // ------------------------------
    // main sequence
    // ------------------------------
    initial begin
        seed       = 68;
        bp_en      = 1'b0;
        bp_now     = 1'b0;
        out_cnt    = 0;
        axis_rst_n = 1'b0;
        awvalid    = 1'b0;
        awaddr     = '0;
        wvalid     = 1'b0;
        wdata      = '0;
        wstrb      = '0;
        bready     = 1'b0;
        arvalid    = 1'b0;
        araddr     = '0;
        rready     = 1'b0;
        ss_tvalid  = 1'b0;
        ss_tdata   = '0;
        ss_tlast   = 1'b0;
        sm_tready  = 1'b1;
        for (int n = 0; n < ELEMS; n++) begin
            exp_c[n] = '0;
        end
        repeat (16) @(posedge axis_clk);
        #DRV_DLY;
        axis_rst_n = 1'b1;

        assert (!sm_tvalid && !ss_tready && !bvalid && !rvalid) else
            stop_run($sformatf("CHECK FAILED at %0t: handshake outputs high after reset", $time));
        axil_read(`MM_CTRL_ADDR, rd_val);
        check_status(rd_val, 1'b0, 1'b1, "status after reset");
        axil_read(12'h004, rd_val);
        check_status(rd_val, 1'b0, 1'b0, "unmapped address");

        // stream offered with no job running
        ss_tvalid = 1'b1;
        ss_tdata  = 32'h1234_5678;
        for (int n = 0; n < 8; n++) begin
            @(posedge axis_clk);
            assert (!ss_tready) else
                stop_run($sformatf("CHECK FAILED at %0t: ss_tready high before start", $time));
            #DRV_DLY;
        end
        ss_tvalid = 1'b0;

        run_job(1'b1);
        axil_read(`MM_CTRL_ADDR, rd_val);
        check_status(rd_val, 1'b1, 1'b1, "first status after job 1");
        axil_read(`MM_CTRL_ADDR, rd_val);
        check_status(rd_val, 1'b0, 1'b1, "second status after job 1");

        run_job(1'b0);
        axil_read(`MM_CTRL_ADDR, rd_val);
        check_status(rd_val, 1'b1, 1'b1, "status after job 2");

        // nothing more should come out
        for (int n = 0; n < 20; n++) begin
            @(posedge axis_clk);
            assert (!sm_tvalid && !ss_tready) else
                stop_run($sformatf("CHECK FAILED at %0t: activity after job end", $time));
            #DRV_DLY;
        end

        $display("TEST OK");
        $finish;
    end

endmodule

//--- mm_accel.f
+incdir+source
source/mm_pkg.sv
source/mm_job_if.sv
source/mm_operand_if.sv
source/mm_axil_regs.sv
source/mm_sequencer.sv
source/mm_operand_loader.sv
source/mm_multiply_engine.sv
source/mm_accel.sv
verif/tb_mm_accel.sv

//--- Bender.yml
package:
  name: mm_accel

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/mm_pkg.sv
      - source/mm_job_if.sv
      - source/mm_operand_if.sv
      - source/mm_axil_regs.sv
      - source/mm_sequencer.sv
      - source/mm_operand_loader.sv
      - source/mm_multiply_engine.sv
      - source/mm_accel.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/tb_mm_accel.sv
